/* dv/icache_tb.sv */
/*
 * Testbench for the instruction cache
 * Clock and reset, fetch and flush stimulus, refill model,
 * assertions and the closing report
 */

module icache_tb
   import icache_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD  = 4;
   // About 40 fetches of up to 25 cycles each, five times over
   localparam int WATCHDOG_NS = 40 * 25 * CLK_PERIOD * 5;

   localparam logic [ADDR_W-1:0] ADDR_A = 32'h0000_1214;   // Set 1
   localparam logic [ADDR_W-1:0] ADDR_N = 32'h0000_4A58;   // Set 5
   localparam logic [ADDR_W-1:0] ADDR_B = 32'h0000_3370;   // Set 7

   logic              clk;
   logic              rst_n;
   logic              bypass_icache, cache_is_bypassed;
   logic              flush_icache, cache_is_flushed;
   logic              flush_set_req, flush_set_ack;
   logic [ADDR_W-1:0] flush_set_addr;
   logic              fetch_req, fetch_gnt, fetch_rvalid;
   logic [ADDR_W-1:0] fetch_addr;
   logic [DATA_W-1:0] fetch_rdata;
   logic              refill_req, refill_gnt, refill_rvalid;
   logic [ADDR_W-1:0] refill_addr;
   logic [DATA_W-1:0] refill_rdata;
   logic              hold_gnt;
   int                refill_count;

   logic [ADDR_W-1:0] same_set [5];   // Set 3, five tags
   int                errors, err_base, tests_run, tests_failed;

   icache_top UUT (
      .clk                 (clk),
      .rst_n               (rst_n),
      .bypass_icache_i     (bypass_icache),
      .cache_is_bypassed_o (cache_is_bypassed),
      .flush_icache_i      (flush_icache),
      .cache_is_flushed_o  (cache_is_flushed),
      .flush_set_req_i     (flush_set_req),
      .flush_set_addr_i    (flush_set_addr),
      .flush_set_ack_o     (flush_set_ack),
      .fetch_req_i         (fetch_req),
      .fetch_addr_i        (fetch_addr),
      .fetch_gnt_o         (fetch_gnt),
      .fetch_rvalid_o      (fetch_rvalid),
      .fetch_rdata_o       (fetch_rdata),
      .refill_req_o        (refill_req),
      .refill_gnt_i        (refill_gnt),
      .refill_addr_o       (refill_addr),
      .refill_rvalid_i     (refill_rvalid),
      .refill_rdata_i      (refill_rdata)
   );

   l2_model u_l2 (
      .clk            (clk),
      .rst_n          (rst_n),
      .hold_gnt_i     (hold_gnt),
      .req_i          (refill_req),
      .addr_i         (refill_addr),
      .gnt_o          (refill_gnt),
      .rvalid_o       (refill_rvalid),
      .rdata_o        (refill_rdata),
      .refill_count_o (refill_count)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("** FAIL **");
      $finish;
   end

   task automatic report_error(input string msg);
      errors++;
      $display("ERROR at %0t ns: %s", $time, msg);
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors != err_base)
      begin
         tests_failed++;
         $display("Test %s: failed, %0d errors", name, errors - err_base);
      end
      else
         $display("Test %s: passed", name);
      err_base = errors;
   endtask

   // Memory answers with the line address four times over
   function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
      return {(DATA_W / ADDR_W){addr[ADDR_W-1:4], 4'h0}};
   endfunction

   // Drive on the falling edge, sample 1 ns later
   task automatic fetch(input logic [ADDR_W-1:0] addr, output int lat);
      @(negedge clk);
      fetch_req  = 1'b1;
      fetch_addr = addr;
      #1;
      while (!fetch_gnt)
      begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      fetch_req = 1'b0;
      lat       = 1;   // Cycles after the grant
      #1;
      while (!fetch_rvalid)
      begin
         if (refill_req)
         begin
            assert (refill_addr == addr)
            else report_error($sformatf("refill address %h for fetch %h", refill_addr, addr));
         end
         @(negedge clk);
         #1;
         lat++;
      end
      assert (fetch_rdata == expected_word(addr))
      else report_error($sformatf("fetch %h returned %h", addr, fetch_rdata));
   endtask

   //////////////////////////////////////////////////
   // Protocol checks
   //////////////////////////////////////////////////

   refill_held_a: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req && !refill_gnt |=> refill_req && $stable(refill_addr))
   else report_error("refill request or address changed before its grant");

   no_gnt_in_refill_a: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req |-> !fetch_gnt)
   else report_error("fetch granted while a refill was waiting");

   bypass_status_a: assert property (@(posedge clk) disable iff (!rst_n)
      bypass_icache && $past(bypass_icache) |-> cache_is_bypassed)
   else report_error("bypass status low while bypass was requested");

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial
   begin
      int                lat;
      int                lat_b;
      int                base;
      int                n;
      logic [ADDR_W-1:0] again [3];

      rst_n          = 1'b0;
      bypass_icache  = 1'b1;
      flush_icache   = 1'b0;
      flush_set_req  = 1'b0;
      flush_set_addr = '0;
      fetch_req      = 1'b0;
      fetch_addr     = '0;
      hold_gnt       = 1'b0;
      errors         = 0;
      err_base       = 0;
      tests_run      = 0;
      tests_failed   = 0;
      for (int k = 0; k < 5; k++)
         same_set[k] = ADDR_W'((k * 9 + 2) * 256 + 'h38);
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      fetch(32'h1000_0004, lat);
      fetch(32'h2345_6788, lat);
      fetch(32'h0000_00F0, lat);
      fetch(32'hDEAD_BEEC, lat);
      assert (cache_is_bypassed) else report_error("cache left bypass mode");
      finish_test("bypass");

      @(negedge clk);
      bypass_icache = 1'b0;
      do
      begin
         @(negedge clk);
         #1;
      end
      while (cache_is_bypassed);
      n = 1;
      while (!cache_is_flushed)
      begin
         @(negedge clk);
         #1;
         n++;
      end
      assert (n <= NB_SETS) else report_error($sformatf("enable flush took %0d cycles", n));
      base = refill_count;
      fetch(ADDR_A, lat);
      assert (refill_count == base + 1) else report_error("first fetch did not refill");
      fetch(ADDR_A, lat);
      assert (lat == 1 && refill_count == base + 1)
      else report_error($sformatf("repeat fetch took %0d cycles or refilled", lat));
      finish_test("enable_miss_hit");

      base = refill_count;
      for (int k = 0; k < 5; k++)
      begin
         fetch(same_set[k], lat);
         assert (refill_count == base + k + 1)
         else report_error($sformatf("new tag %h did not refill", same_set[k]));
      end
      base = refill_count;
      for (int k = 0; k < 5; k++)
         fetch(same_set[k], lat);
      assert (refill_count > base) else report_error("five tags fit in a four way set");
      finish_test("replacement");

      fetch(same_set[0], lat);   // Line present before its set is flushed
      @(negedge clk);
      flush_set_addr = same_set[0];
      flush_set_req  = 1'b1;
      do
      begin
         @(negedge clk);
         #1;
      end
      while (!flush_set_ack);
      @(negedge clk);
      flush_set_req = 1'b0;
      base          = refill_count;
      fetch(same_set[0], lat);
      assert (refill_count == base + 1) else report_error("flushed set still hit");
      fetch(ADDR_A, lat);
      assert (lat == 1 && refill_count == base + 1)
      else report_error("line in another set was lost by the set flush");
      finish_test("set_flush");

      @(posedge clk);
      hold_gnt = 1'b1;   // Model holds back its grants
      fork
         fetch(ADDR_N, lat);
         begin
            do
            begin
               @(negedge clk);
               #1;
            end
            while (!refill_req);
            repeat (3) @(negedge clk);
            flush_icache = 1'b1;
            repeat (4) @(posedge clk);
            hold_gnt = 1'b0;
            do
            begin
               @(negedge clk);
               #1;
            end
            while (!cache_is_flushed);
            @(negedge clk);
            flush_icache = 1'b0;
         end
         begin
            // Second fetch waits behind the held refill and the flush
            do
            begin
               @(negedge clk);
               #1;
            end
            while (!refill_req);
            fetch(ADDR_B, lat_b);
         end
      join
      again[0] = ADDR_A;
      again[1] = same_set[0];
      again[2] = ADDR_N;
      for (int k = 0; k < 3; k++)
      begin
         base = refill_count;
         fetch(again[k], lat);
         assert (refill_count == base + 1)
         else report_error($sformatf("%h hit after the full flush", again[k]));
      end
      finish_test("full_flush");

      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

/* dv/l2_model.sv */
/*
 * Refill memory model for the instruction cache testbench
 * Random grant and response delays from a Galois LFSR,
 * line address data and a refill counter
 */

module l2_model
   import icache_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              hold_gnt_i,   // Testbench back-pressure
   input  logic              req_i,
   input  logic [ADDR_W-1:0] addr_i,
   output logic              gnt_o,
   output logic              rvalid_o,
   output logic [DATA_W-1:0] rdata_o,
   output int                refill_count_o
);

   timeunit 1ns;
   timeprecision 1ps;

   logic [31:0]       lfsr;
   logic [ADDR_W-1:0] addr_q;
   logic              waiting;   // Request seen, grant delay running
   logic              busy;      // Granted, beat not yet returned
   int                gnt_wait;
   int                rsp_wait;

   // Right shift Galois form, taps 32 30 26 25
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
   endfunction

   function automatic int draw_bits(input int nb);
      int val;
      val = 0;
      for (int k = 0; k < nb; k++)
      begin
         val  = (val << 1) | int'(lfsr[0]);
         lfsr = lfsr_next(lfsr);
      end
      return val;
   endfunction

   //////////////////////////////////////////////////
   // Outputs change on the falling edge only
   //////////////////////////////////////////////////

   initial
   begin
      lfsr           = 32'h3557_d1b1;
      gnt_o          = 1'b0;
      rvalid_o       = 1'b0;
      rdata_o        = '0;
      refill_count_o = 0;
      addr_q         = '0;
      waiting        = 1'b0;
      busy           = 1'b0;
      gnt_wait       = 0;
      rsp_wait       = 0;
      forever
      begin
         @(negedge clk);
         gnt_o    = 1'b0;
         rvalid_o = 1'b0;
         if (!rst_n)
         begin
            waiting = 1'b0;
            busy    = 1'b0;
         end
         else if (busy)
         begin
            rsp_wait--;
            if (rsp_wait == 0)
            begin
               rvalid_o = 1'b1;
               rdata_o  = {(DATA_W / ADDR_W){addr_q[ADDR_W-1:4], 4'h0}};
               busy     = 1'b0;
            end
         end
         else
         begin
            if (req_i && !waiting)
            begin
               waiting  = 1'b1;
               gnt_wait = draw_bits(2);   // 0 to 3 cycles
            end
            if (waiting && !hold_gnt_i)
            begin
               if (gnt_wait == 0)
               begin
                  gnt_o    = 1'b1;
                  addr_q   = addr_i;
                  rsp_wait = draw_bits(2) + 1;   // 1 to 4 cycles after grant
                  busy     = 1'b1;
                  waiting  = 1'b0;
                  refill_count_o++;
               end
               else
                  gnt_wait--;
            end
         end
      end
   end

endmodule

/* rtl/data_array.sv */
/*
 * Data store, 4 ways by 16 sets of 128-bit words
 * One write or one read per cycle, read data registered
 */

module data_array
   import icache_pkg::*;
(
   input  logic                           clk,
   input  array_req_t                     req_i,
   input  logic [DATA_W-1:0]              wdata_i,
   output logic [NB_WAYS-1:0][DATA_W-1:0] rdata_o
);

   logic [NB_WAYS-1:0][DATA_W-1:0] mem [NB_SETS];

   always_ff @(posedge clk)
   begin
      if (req_i.we)
      begin
         for (int w = 0; w < NB_WAYS; w++)
         begin
            if (req_i.way_en[w])
               mem[req_i.set][w] <= wdata_i;
         end
      end
      else if (|req_i.way_en)
         rdata_o <= mem[req_i.set];   // Hit way picked by the controller
   end

endmodule

/* rtl/icache_fsm.sv */
/*
 * Instruction cache controller
 * Bypass, full and single set flush, tag lookup,
 * miss refill and victim way choice
 */

module icache_fsm
   import icache_pkg::*;
(
   input  logic                           clk,
   input  logic                           rst_n,

   input  logic                           bypass_icache_i,
   output logic                           cache_is_bypassed_o,
   input  logic                           flush_icache_i,
   output logic                           cache_is_flushed_o,
   input  logic                           flush_set_req_i,
   input  logic [ADDR_W-1:0]              flush_set_addr_i,
   output logic                           flush_set_ack_o,

   input  logic                           fetch_req_i,
   input  logic [ADDR_W-1:0]              fetch_addr_i,
   output logic                           fetch_gnt_o,
   output logic                           fetch_rvalid_o,
   output logic [DATA_W-1:0]              fetch_rdata_o,

   output logic                           refill_req_o,
   input  logic                           refill_gnt_i,
   output logic [ADDR_W-1:0]              refill_addr_o,
   input  logic                           refill_rvalid_i,
   input  logic [DATA_W-1:0]              refill_rdata_i,

   input  way_oh_t                        way_match_i,
   input  logic [WAY_IDX_W-1:0]           hit_way_i,
   input  logic                           all_valid_i,
   input  way_oh_t                        first_free_i,
   input  way_oh_t                        victim_way_i,
   input  logic [NB_WAYS-1:0][DATA_W-1:0] data_rdata_i,

   output array_req_t                     tag_req_o,
   output tag_entry_t                     tag_wdata_o,
   output array_req_t                     data_req_o,
   output logic [TAG_W-1:0]               fetch_tag_o,
   output logic                           victim_step_o
);

   ctrl_state_e       state_q, state_d;
   logic [ADDR_W-1:0] fetch_addr_q;    // Address of the fetch in flight
   way_oh_t           refill_way_q, refill_way_d;
   logic              save_way;
   logic [SET_W-1:0]  flush_cnt_q, flush_cnt_d;
   logic              bypass_pend_q;   // Bypassed refill not yet returned
   logic              bypass_gnt;
   logic              capture_addr;

   logic [SET_W-1:0]  fetch_set;
   logic [SET_W-1:0]  held_set;

   assign fetch_set   = fetch_addr_i[SET_LSB +: SET_W];
   assign held_set    = fetch_addr_q[SET_LSB +: SET_W];
   assign fetch_tag_o = fetch_addr_q[TAG_LSB +: TAG_W];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q       <= ST_DISABLED;
         flush_cnt_q   <= '0;
         refill_way_q  <= '0;
         bypass_pend_q <= 1'b0;
      end
      else
      begin
         state_q     <= state_d;
         flush_cnt_q <= flush_cnt_d;
         if (save_way)
            refill_way_q <= refill_way_d;
         if (bypass_gnt)
            bypass_pend_q <= 1'b1;
         else if (refill_rvalid_i)
            bypass_pend_q <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (capture_addr)
         fetch_addr_q <= fetch_addr_i;
   end

   //////////////////////////////////////////////////
   // Next state and outputs
   //////////////////////////////////////////////////

   always_comb
   begin
      state_d             = state_q;
      flush_cnt_d         = flush_cnt_q;
      capture_addr        = 1'b0;
      bypass_gnt          = 1'b0;
      save_way            = 1'b0;
      refill_way_d        = '0;
      victim_step_o       = 1'b0;

      cache_is_bypassed_o = 1'b0;
      cache_is_flushed_o  = 1'b0;
      flush_set_ack_o     = 1'b0;

      fetch_gnt_o         = 1'b0;
      fetch_rvalid_o      = 1'b0;
      fetch_rdata_o       = refill_rdata_i;
      refill_req_o        = 1'b0;
      refill_addr_o       = fetch_addr_q;

      tag_req_o   = '{way_en: '0, we: 1'b0, set: fetch_set};
      data_req_o  = '{way_en: '0, we: 1'b0, set: fetch_set};
      tag_wdata_o = '{valid: 1'b1, tag: fetch_tag_o};

      case (state_q)
         ST_DISABLED:
         begin
            flush_set_ack_o     = 1'b1;
            cache_is_bypassed_o = 1'b1;
            cache_is_flushed_o  = 1'b1;
            flush_cnt_d         = '0;
            capture_addr        = 1'b1;
            fetch_rvalid_o      = refill_rvalid_i;   // Single beat response
            if (bypass_icache_i)
            begin
               // Keep one bypassed refill in flight
               fetch_gnt_o = fetch_req_i & (~bypass_pend_q | refill_rvalid_i);
               bypass_gnt  = fetch_gnt_o;
               if (fetch_gnt_o)
                  state_d = ST_BYPASS_DELAY;
            end
            else if (!bypass_pend_q)
               state_d = ST_FLUSH_ALL;          // Drained, enable the cache
         end

         ST_BYPASS_DELAY:
         begin
            flush_set_ack_o     = 1'b1;
            cache_is_bypassed_o = 1'b1;
            cache_is_flushed_o  = 1'b1;
            fetch_rvalid_o      = refill_rvalid_i;
            refill_req_o        = 1'b1;
            if (refill_gnt_i)
               state_d = ST_DISABLED;
         end

         ST_FLUSH_ALL:
         begin
            flush_set_ack_o = 1'b1;
            tag_req_o       = '{way_en: '1, we: 1'b1, set: flush_cnt_q};
            tag_wdata_o     = '0;
            if (flush_cnt_q == SET_W'(NB_SETS - 1))
            begin
               cache_is_flushed_o = 1'b1;
               flush_cnt_d        = '0;
               state_d            = ST_IDLE;
            end
            else
               flush_cnt_d = flush_cnt_q + 1'b1;
         end

         ST_FLUSH_SET:
         begin
            flush_set_ack_o = 1'b1;
            tag_req_o       = '{way_en: '1, we: 1'b1,
                                set: flush_set_addr_i[SET_LSB +: SET_W]};
            tag_wdata_o     = '0;
            state_d         = ST_IDLE;
         end

         ST_IDLE:
         begin
            if (bypass_icache_i)
               state_d = ST_DISABLED;
            else if (flush_icache_i)
               state_d = ST_FLUSH_ALL;
            else if (flush_set_req_i)
               state_d = ST_FLUSH_SET;
            else if (fetch_req_i)
            begin
               fetch_gnt_o       = 1'b1;
               capture_addr      = 1'b1;
               tag_req_o.way_en  = '1;   // Read all ways of the set
               data_req_o.way_en = '1;
               state_d           = ST_LOOKUP;
            end
         end

         ST_LOOKUP:
         begin
            if (|way_match_i)
            begin
               fetch_rvalid_o    = 1'b1;
               fetch_rdata_o     = data_rdata_i[hit_way_i];
               // Back to back hits keep the pipe full
               fetch_gnt_o       = fetch_req_i;
               capture_addr      = fetch_req_i;
               tag_req_o.way_en  = {NB_WAYS{fetch_req_i}};
               data_req_o.way_en = {NB_WAYS{fetch_req_i}};
               if (!fetch_req_i)
                  state_d = ST_IDLE;
            end
            else
            begin
               refill_req_o = 1'b1;
               save_way     = 1'b1;
               if (all_valid_i)
               begin
                  refill_way_d  = victim_way_i;   // Set full, evict
                  victim_step_o = 1'b1;
               end
               else
                  refill_way_d = first_free_i;
               state_d = refill_gnt_i ? ST_WAIT_DONE : ST_WAIT_GNT;
            end
         end

         ST_WAIT_GNT:
         begin
            refill_req_o = 1'b1;
            if (refill_gnt_i)
               state_d = ST_WAIT_DONE;
         end

         ST_WAIT_DONE:
         begin
            fetch_rvalid_o = refill_rvalid_i;
            // Beat goes to the core and into the chosen way together
            tag_req_o  = '{way_en: refill_way_q & {NB_WAYS{refill_rvalid_i}},
                           we: 1'b1, set: held_set};
            data_req_o = '{way_en: refill_way_q & {NB_WAYS{refill_rvalid_i}},
                           we: 1'b1, set: held_set};
            if (refill_rvalid_i)
               state_d = ST_IDLE;
         end

         default:
         begin
            state_d = ST_DISABLED;
         end
      endcase
   end

endmodule

/* rtl/icache_pkg.sv */
/*
 * Shared definitions for the private instruction cache
 * - address split and array geometry
 * - tag entry and array request structs
 * - controller state encoding
 */

package icache_pkg;

   //////////////////////////////////////////////////
   // Geometry
   //////////////////////////////////////////////////

   localparam int ADDR_W      = 32;
   localparam int DATA_W      = 128;

   localparam int NB_WAYS     = 4;
   localparam int WAY_IDX_W   = 2;
   localparam int NB_SETS     = 16;
   localparam int SET_W       = 4;

   // Address fields, 16 byte line
   localparam int SET_LSB     = 4;
   localparam int TAG_W       = 7;
   localparam int TAG_LSB     = 8;
   localparam int TAG_ENTRY_W = 8;   // Valid bit plus tag

   localparam logic [7:0] LFSR_SEED = 8'hA5;

   //////////////////////////////////////////////////
   // Types
   //////////////////////////////////////////////////

   typedef logic [NB_WAYS-1:0] way_oh_t;

   typedef struct packed {
      logic             valid;
      logic [TAG_W-1:0] tag;
   } tag_entry_t;

   // One access per cycle to a tag or data array
   typedef struct packed {
      way_oh_t          way_en;   // Ways taking part
      logic             we;       // Write the enabled ways, else read
      logic [SET_W-1:0] set;
   } array_req_t;

   typedef enum logic [3:0] {
      ST_DISABLED,
      ST_BYPASS_DELAY,
      ST_FLUSH_ALL,
      ST_FLUSH_SET,
      ST_IDLE,
      ST_LOOKUP,
      ST_WAIT_GNT,
      ST_WAIT_DONE
   } ctrl_state_e;

endpackage

/* rtl/icache_top.sv */
/*
 * Instruction cache top level
 * Controller, tag compare, victim generator,
 * tag store and data store
 */

module icache_top
   import icache_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,

   input  logic              bypass_icache_i,
   output logic              cache_is_bypassed_o,
   input  logic              flush_icache_i,
   output logic              cache_is_flushed_o,

   input  logic              flush_set_req_i,
   input  logic [ADDR_W-1:0] flush_set_addr_i,
   output logic              flush_set_ack_o,

   // Core fetch port
   input  logic              fetch_req_i,
   input  logic [ADDR_W-1:0] fetch_addr_i,
   output logic              fetch_gnt_o,
   output logic              fetch_rvalid_o,
   output logic [DATA_W-1:0] fetch_rdata_o,

   // Refill port
   output logic              refill_req_o,
   input  logic              refill_gnt_i,
   output logic [ADDR_W-1:0] refill_addr_o,
   input  logic              refill_rvalid_i,
   input  logic [DATA_W-1:0] refill_rdata_i
);

   array_req_t                         tag_req;
   tag_entry_t                         tag_wdata;
   tag_entry_t [NB_WAYS-1:0]           tag_rdata;
   array_req_t                         data_req;
   logic       [NB_WAYS-1:0][DATA_W-1:0] data_rdata;

   way_oh_t                            way_match;
   logic       [WAY_IDX_W-1:0]         hit_way;
   logic                               all_valid;
   way_oh_t                            first_free;
   way_oh_t                            victim_way;
   logic                               victim_step;
   logic       [TAG_W-1:0]             fetch_tag;

   icache_fsm u_fsm (
      .clk                 (clk),
      .rst_n               (rst_n),
      .bypass_icache_i     (bypass_icache_i),
      .cache_is_bypassed_o (cache_is_bypassed_o),
      .flush_icache_i      (flush_icache_i),
      .cache_is_flushed_o  (cache_is_flushed_o),
      .flush_set_req_i     (flush_set_req_i),
      .flush_set_addr_i    (flush_set_addr_i),
      .flush_set_ack_o     (flush_set_ack_o),
      .fetch_req_i         (fetch_req_i),
      .fetch_addr_i        (fetch_addr_i),
      .fetch_gnt_o         (fetch_gnt_o),
      .fetch_rvalid_o      (fetch_rvalid_o),
      .fetch_rdata_o       (fetch_rdata_o),
      .refill_req_o        (refill_req_o),
      .refill_gnt_i        (refill_gnt_i),
      .refill_addr_o       (refill_addr_o),
      .refill_rvalid_i     (refill_rvalid_i),
      .refill_rdata_i      (refill_rdata_i),
      .way_match_i         (way_match),
      .hit_way_i           (hit_way),
      .all_valid_i         (all_valid),
      .first_free_i        (first_free),
      .victim_way_i        (victim_way),
      .data_rdata_i        (data_rdata),
      .tag_req_o           (tag_req),
      .tag_wdata_o         (tag_wdata),
      .data_req_o          (data_req),
      .fetch_tag_o         (fetch_tag),
      .victim_step_o       (victim_step)
   );

   tag_compare u_tag_compare (
      .tag_rdata_i  (tag_rdata),
      .fetch_tag_i  (fetch_tag),
      .way_match_o  (way_match),
      .hit_way_o    (hit_way),
      .all_valid_o  (all_valid),
      .first_free_o (first_free)
   );

   repl_lfsr u_repl_lfsr (
      .clk          (clk),
      .rst_n        (rst_n),
      .step_i       (victim_step),
      .victim_way_o (victim_way)
   );

   tag_array u_tag_array (
      .clk     (clk),
      .rst_n   (rst_n),
      .req_i   (tag_req),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rdata)
   );

   // Refill beat is the only write source
   data_array u_data_array (
      .clk     (clk),
      .req_i   (data_req),
      .wdata_i (refill_rdata_i),
      .rdata_o (data_rdata)
   );

endmodule

/* rtl/repl_lfsr.sv */
/*
 * Victim way generator
 * 8-bit Fibonacci LFSR, low bits decoded to one-hot
 */

module repl_lfsr
   import icache_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    step_i,
   output way_oh_t victim_way_o
);

   logic [7:0] lfsr_q;
   logic       feedback;

   // x^8 + x^6 + x^5 + x^4 + 1, maximal length
   assign feedback = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         lfsr_q <= LFSR_SEED;
      else if (step_i)
         lfsr_q <= {lfsr_q[6:0], feedback};
   end

   assign victim_way_o = way_oh_t'(1 << lfsr_q[WAY_IDX_W-1:0]);

endmodule

/* rtl/tag_array.sv */
/*
 * Tag store, 4 ways by 16 sets in registers
 * One write or one read per cycle, read data registered
 */

module tag_array
   import icache_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  array_req_t               req_i,
   input  tag_entry_t               wdata_i,
   output tag_entry_t [NB_WAYS-1:0] rdata_o
);

   logic [NB_WAYS-1:0][TAG_ENTRY_W-1:0] mem [NB_SETS];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int s = 0; s < NB_SETS; s++)
            mem[s] <= '0;   // All lines invalid
         rdata_o <= '0;
      end
      else if (req_i.we)
      begin
         for (int w = 0; w < NB_WAYS; w++)
         begin
            if (req_i.way_en[w])
               mem[req_i.set][w] <= wdata_i;
         end
      end
      else if (|req_i.way_en)
         rdata_o <= mem[req_i.set];   // Whole set for the compare
   end

endmodule

/* rtl/tag_compare.sv */
/*
 * Tag compare
 * Per way valid and match, hit way index,
 * all valid flag and free way one-hot
 */

module tag_compare
   import icache_pkg::*;
(
   input  tag_entry_t [NB_WAYS-1:0] tag_rdata_i,
   input  logic [TAG_W-1:0]         fetch_tag_i,
   output way_oh_t                  way_match_o,
   output logic [WAY_IDX_W-1:0]     hit_way_o,
   output logic                     all_valid_o,
   output way_oh_t                  first_free_o
);

   way_oh_t way_valid;

   always_comb
   begin
      for (int k = 0; k < NB_WAYS; k++)
      begin
         way_valid[k]   = tag_rdata_i[k].valid;
         way_match_o[k] = tag_rdata_i[k].valid && (tag_rdata_i[k].tag == fetch_tag_i);
      end
   end

   assign all_valid_o = &way_valid;

   // Highest index wins in both scans
   always_comb
   begin
      hit_way_o    = '0;
      first_free_o = '0;
      for (int k = 0; k < NB_WAYS; k++)
      begin
         if (way_match_o[k])
            hit_way_o = WAY_IDX_W'(k);
         if (!way_valid[k])
            first_free_o = way_oh_t'(1 << k);
      end
   end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the instruction cache testbench with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
   --top-module icache_tb -Mdir obj_dir -f vlog.f

./obj_dir/Vicache_tb | tee sim.log

if grep -qF '** PASS **' sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

/* vlog.f */
rtl/icache_pkg.sv
rtl/tag_compare.sv
rtl/repl_lfsr.sv
rtl/tag_array.sv
rtl/data_array.sv
rtl/icache_fsm.sv
rtl/icache_top.sv
dv/l2_model.sv
dv/icache_tb.sv
